/* rtl/otter_pkg.sv */
package otter_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths and basic types
    ////////////////////////////////////////////////////////////////////

    localparam int xlen = 32;
    // First fetch address after reset
    localparam logic [xlen-1:0] reset_vec = '0;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Branch kinds in funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Load and store sizes in funct3
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    ////////////////////////////////////////////////////////////////////
    // Instruction word and its format views
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_fmt_t;

    // Same fetched word seen through every format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
        word_t  raw;
    } instr_u;

    ////////////////////////////////////////////////////////////////////
    // Control selects and bundles
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_copy_b
    } alu_op_e;

    typedef enum logic {src_a_rs1, src_a_pc} src_a_e;
    typedef enum logic {src_b_rs2, src_b_imm} src_b_e;
    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc_inc} wb_sel_e;
    typedef enum logic [1:0] {pc_src_inc, pc_src_branch, pc_src_jal, pc_src_jalr} pc_src_e;

    typedef struct packed {
        alu_op_e    alu_op;
        src_a_e     src_a;
        src_b_e     src_b;
        wb_sel_e    wb_sel;
        pc_src_e    pc_src;
        logic [2:0] funct3;
        word_t      imm;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
    } ctrl_t;

    // Outgoing data memory request
    typedef struct packed {
        logic       r_en;
        logic       w_en;
        logic [3:0] strb;
        word_t      addr;
        word_t      w_data;
    } dmem_req_t;

endpackage

/* rtl/otter_regfile.sv */
`timescale 1ns/1ps

module otter_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             w_en,
    input  otter_pkg::ctrl_t ctrl,
    input  otter_pkg::word_t w_data,
    output otter_pkg::word_t rs1_data,
    output otter_pkg::word_t rs2_data
);
    import otter_pkg::*;

    // x0 slot is never written
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (w_en && ctrl.rd != '0) begin
            regs[ctrl.rd] <= w_data;
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rs1_data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
    assign rs2_data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

    // A write aimed at x0 leaves it reading zero afterwards
    ap_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (w_en && ctrl.rd == '0) |=> (ctrl.rs1 != '0 || rs1_data == '0));

endmodule

/* rtl/otter_alu.sv */
`timescale 1ns/1ps

module otter_alu (
    input  otter_pkg::ctrl_t ctrl,
    input  otter_pkg::word_t rs1_data,
    input  otter_pkg::word_t rs2_data,
    input  otter_pkg::word_t pc,
    input  otter_pkg::word_t pc_inc,
    input  otter_pkg::word_t load_data,
    output otter_pkg::word_t result,
    output otter_pkg::word_t wb_data
);
    import otter_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    // Operand selectors
    assign op_a  = (ctrl.src_a == src_a_pc) ? pc : rs1_data;
    assign op_b  = (ctrl.src_b == src_b_imm) ? ctrl.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {31'b0, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = $signed(op_a) >>> shamt;
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            // LUI passes the U immediate through
            default:    result = op_b;
        endcase
    end

    // Register write-back source
    always_comb begin
        case (ctrl.wb_sel)
            wb_load:   wb_data = load_data;
            wb_pc_inc: wb_data = pc_inc;
            default:   wb_data = result;
        endcase
    end

endmodule

/* rtl/otter_pc_unit.sv */
`timescale 1ns/1ps

module otter_pc_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             w_en,
    input  otter_pkg::ctrl_t ctrl,
    input  otter_pkg::word_t rs1_data,
    input  otter_pkg::word_t rs2_data,
    output otter_pkg::word_t pc,
    output otter_pkg::word_t pc_inc
);
    import otter_pkg::*;

    word_t pc_next;
    word_t rel_target;
    word_t jalr_target;
    logic  br_eq;
    logic  br_lt;
    logic  br_ltu;
    logic  br_taken;

    //////////////////////////////////////////////////////////////////////
    // Target generation
    //////////////////////////////////////////////////////////////////////

    assign pc_inc = pc + 32'd4;

    // Branch and JAL both add their immediate to the PC
    assign rel_target = pc + ctrl.imm;

    // JALR drops bit 0 of the sum
    assign jalr_target = (rs1_data + ctrl.imm) & ~32'd1;

    //////////////////////////////////////////////////////////////////////
    // Branch condition
    //////////////////////////////////////////////////////////////////////

    assign br_eq  = rs1_data == rs2_data;
    assign br_lt  = $signed(rs1_data) < $signed(rs2_data);
    assign br_ltu = rs1_data < rs2_data;

    always_comb begin
        case (ctrl.funct3)
            f3_beq:  br_taken = br_eq;
            f3_bne:  br_taken = !br_eq;
            f3_blt:  br_taken = br_lt;
            f3_bge:  br_taken = !br_lt;
            f3_bltu: br_taken = br_ltu;
            f3_bgeu: br_taken = !br_ltu;
            default: br_taken = 1'b0;
        endcase
    end

    // Next PC select
    always_comb begin
        case (ctrl.pc_src)
            pc_src_branch: pc_next = br_taken ? rel_target : pc_inc;
            pc_src_jal:    pc_next = rel_target;
            pc_src_jalr:   pc_next = jalr_target;
            default:       pc_next = pc_inc;
        endcase
    end

    // PC moves once per instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_vec;
        end else if (w_en) begin
            pc <= pc_next;
        end
    end

    // Every committed PC stays word aligned
    ap_pc_align: assert property (@(posedge clk) disable iff (!rst_n)
        w_en |=> pc[1:0] == 2'b00);

endmodule

/* rtl/otter_mem_align.sv */
`timescale 1ns/1ps

module otter_mem_align (
    input  otter_pkg::ctrl_t     ctrl,
    input  logic                 r_en,
    input  logic                 w_en,
    input  otter_pkg::word_t     addr,
    input  otter_pkg::word_t     rs2_data,
    input  otter_pkg::word_t     dmem_r_data,
    output otter_pkg::dmem_req_t req,
    output otter_pkg::word_t     load_data
);
    import otter_pkg::*;

    logic [1:0] offset;
    logic [3:0] base_strb;
    word_t      r_shifted;

    assign offset = addr[1:0];

    // One, two or four lanes for sb, sh, sw
    always_comb begin
        case (ctrl.funct3)
            f3_byte: base_strb = 4'b0001;
            f3_half: base_strb = 4'b0011;
            default: base_strb = 4'b1111;
        endcase
    end

    // Store data and lanes move up to the byte offset
    assign req.r_en   = r_en;
    assign req.w_en   = w_en;
    assign req.strb   = base_strb << offset;
    assign req.addr   = addr;
    assign req.w_data = rs2_data << {offset, 3'b000};

    // Loaded bytes come down to bit 0 before extension
    assign r_shifted = dmem_r_data >> {offset, 3'b000};

    always_comb begin
        case (ctrl.funct3)
            f3_byte:   load_data = {{24{r_shifted[7]}}, r_shifted[7:0]};
            f3_half:   load_data = {{16{r_shifted[15]}}, r_shifted[15:0]};
            f3_byte_u: load_data = {24'b0, r_shifted[7:0]};
            f3_half_u: load_data = {16'b0, r_shifted[15:0]};
            f3_word:   load_data = r_shifted;
            default:   load_data = r_shifted;
        endcase
    end

endmodule

/* rtl/otter_control.sv */
`timescale 1ns/1ps

module otter_control (
    input  logic              clk,
    input  logic              rst_n,
    input  otter_pkg::instr_u instr,
    output otter_pkg::ctrl_t  ctrl,
    output logic              pc_w_en,
    output logic              rf_w_en,
    output logic              mem_r_en,
    output logic              mem_w_en
);
    import otter_pkg::*;

    typedef enum logic [1:0] {st_fetch, st_exec, st_wb} state_e;

    state_e state;
    state_e state_next;
    word_t  imm;
    logic   has_rd;
    logic   is_load;
    logic   is_store;

    // ALU op from funct3, alt is instruction bit 30
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                           input logic reg_op);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && reg_op) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_fetch;
        end else begin
            state <= state_next;
        end
    end

    // Loads take an extra cycle for the synchronous data read
    always_comb begin
        case (state)
            st_fetch: state_next = st_exec;
            st_exec:  state_next = is_load ? st_wb : st_fetch;
            default:  state_next = st_fetch;
        endcase
    end

    // PC and register file commit together at the last cycle
    assign pc_w_en  = (state == st_exec && !is_load) || state == st_wb;
    assign rf_w_en  = pc_w_en && has_rd;
    assign mem_r_en = state == st_exec && is_load;
    assign mem_w_en = state == st_exec && is_store;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    // Immediate by format, sign-extended
    always_comb begin
        case (instr.r_fmt.opcode)
            op_lui, op_auipc: imm = {instr.u_fmt.imm_31_12, 12'b0};
            op_jal: imm = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                           instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            op_branch: imm = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                              instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            op_store: imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                             instr.s_fmt.imm_4_0};
            // JALR, loads and ALU immediates
            default: imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        ctrl.src_a  = src_a_rs1;
        ctrl.src_b  = src_b_imm;
        ctrl.wb_sel = wb_alu;
        ctrl.pc_src = pc_src_inc;
        ctrl.funct3 = instr.i_fmt.funct3;
        ctrl.imm    = imm;
        ctrl.rd     = instr.r_fmt.rd;
        ctrl.rs1    = instr.r_fmt.rs1;
        ctrl.rs2    = instr.r_fmt.rs2;
        has_rd      = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        case (instr.r_fmt.opcode)
            op_lui: begin
                ctrl.alu_op = alu_copy_b;
                has_rd      = 1'b1;
            end
            op_auipc: begin
                ctrl.src_a = src_a_pc;
                has_rd     = 1'b1;
            end
            op_jal: begin
                ctrl.pc_src = pc_src_jal;
                ctrl.wb_sel = wb_pc_inc;
                has_rd      = 1'b1;
            end
            op_jalr: begin
                ctrl.pc_src = pc_src_jalr;
                ctrl.wb_sel = wb_pc_inc;
                has_rd      = 1'b1;
            end
            op_branch: ctrl.pc_src = pc_src_branch;
            op_load: begin
                ctrl.wb_sel = wb_load;
                has_rd      = 1'b1;
                is_load     = 1'b1;
            end
            // Address is rs1 plus S immediate
            op_store: is_store = 1'b1;
            op_imm: begin
                ctrl.alu_op = alu_decode(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b0);
                has_rd      = 1'b1;
            end
            op_reg: begin
                ctrl.alu_op = alu_decode(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b1);
                ctrl.src_b  = src_b_rs2;
                has_rd      = 1'b1;
            end
            // Unknown opcodes just advance the PC
            default: ;
        endcase
    end

    // A read never overlaps a write, and is followed by write-back
    ap_load_seq: assert property (@(posedge clk) disable iff (!rst_n)
        mem_r_en |-> !mem_w_en ##1 (state == st_wb && !mem_r_en && !mem_w_en));

    // Fetch only waits for the instruction word
    ap_fetch_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state == st_fetch |-> !(pc_w_en || rf_w_en || mem_r_en || mem_w_en));

endmodule

/* rtl/otter_mcu.sv */
`timescale 1ns/1ps

module otter_mcu (
    input  logic                 clk,
    input  logic                 rst_n,
    output otter_pkg::word_t     imem_addr,
    input  otter_pkg::word_t     imem_r_data,
    output otter_pkg::dmem_req_t dmem_req,
    input  otter_pkg::word_t     dmem_r_data
);
    import otter_pkg::*;

    instr_u instr;
    ctrl_t  ctrl;
    logic   pc_w_en;
    logic   rf_w_en;
    logic   mem_r_en;
    logic   mem_w_en;
    word_t  pc;
    word_t  pc_inc;
    word_t  rs1_data;
    word_t  rs2_data;
    word_t  alu_result;
    word_t  wb_data;
    word_t  load_data;

    // Fetched word as seen by the decoder
    assign instr.raw = imem_r_data;

    // Instruction memory always follows the PC
    assign imem_addr = pc;

    ////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////

    otter_control u_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .ctrl     (ctrl),
        .pc_w_en  (pc_w_en),
        .rf_w_en  (rf_w_en),
        .mem_r_en (mem_r_en),
        .mem_w_en (mem_w_en)
    );

    ////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////

    otter_pc_unit u_pc_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .w_en     (pc_w_en),
        .ctrl     (ctrl),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .pc_inc   (pc_inc)
    );

    otter_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .w_en     (rf_w_en),
        .ctrl     (ctrl),
        .w_data   (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    otter_alu u_alu (
        .ctrl      (ctrl),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .pc        (pc),
        .pc_inc    (pc_inc),
        .load_data (load_data),
        .result    (alu_result),
        .wb_data   (wb_data)
    );

    // ALU result doubles as the byte address
    otter_mem_align u_mem_align (
        .ctrl        (ctrl),
        .r_en        (mem_r_en),
        .w_en        (mem_w_en),
        .addr        (alu_result),
        .rs2_data    (rs2_data),
        .dmem_r_data (dmem_r_data),
        .req         (dmem_req),
        .load_data   (load_data)
    );

endmodule

/* bench/otter_tb.sv */
`timescale 1ns/1ps

module otter_tb;
    import otter_pkg::*;

    // Result words live below the end marker and load sources at 0x200
    localparam word_t end_addr   = 32'h0000_0100;
    localparam int    max_cycles = 2000;
    localparam word_t nop_word   = 32'h0000_0013;
    localparam word_t mark_value = 32'h1234_5678;

    logic      clk;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_r_data;
    dmem_req_t dmem_req;
    word_t     dmem_r_data;

    // Memory models of 256 words each
    word_t rom [256];
    word_t ram [256];
    word_t exp_ram [64];
    word_t fetch_q;
    word_t load_q;
    int    lane;

    // Program builder and bookkeeping
    int    pc_emit;
    int    slot;
    int    errors;
    int    checks;
    word_t rng_state;

    otter_mcu dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .imem_r_data (imem_r_data),
        .dmem_req    (dmem_req),
        .dmem_r_data (dmem_r_data)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////

    // Synchronous reads, byte-strobed writes, outputs 1 ns after the edge
    always @(posedge clk) begin
        fetch_q = rom[imem_addr[9:2]];
        // Data word only moves on a read strobe
        if (dmem_req.r_en === 1'b1) begin
            load_q = ram[dmem_req.addr[9:2]];
        end
        if (dmem_req.w_en === 1'b1) begin
            for (lane = 0; lane < 4; lane++) begin
                if (dmem_req.strb[lane]) begin
                    ram[dmem_req.addr[9:2]][lane*8 +: 8] = dmem_req.w_data[lane*8 +: 8];
                end
            end
        end
        #1;
        imem_r_data = fetch_q;
        dmem_r_data = load_q;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // xorshift32 generator
    function automatic word_t next_random();
        word_t x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // Background pattern that mixes every address bit
    function automatic word_t fill_word(input int idx);
        return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    // One instruction encoder per format
    function automatic word_t encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t encode_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic emit(input word_t w);
        rom[pc_emit] = w;
        pc_emit++;
    endtask

    // LUI then ADDI with the carry folded into the upper part
    task automatic load_imm(input logic [4:0] rd, input word_t v);
        word_t upper;
        upper = v + 32'h800;
        emit(encode_u(upper[31:12], rd, op_lui));
        emit(encode_i(v[11:0], rd, 3'b000, rd, op_imm));
    endtask

    // Store a register into the next result word
    task automatic save_reg(input logic [4:0] rs, input word_t expected);
        emit(encode_s(12'(slot * 4), rs, 5'd0, 3'b010));
        exp_ram[slot] = expected;
        slot++;
    endtask

    task automatic start_program();
        int i;
        for (i = 0; i < 256; i++) begin
            rom[i] = nop_word;
            ram[i] = fill_word(i);
        end
        for (i = 0; i < 64; i++) begin
            exp_ram[i] = fill_word(i);
        end
        pc_emit = 0;
        slot    = 0;
    endtask

    // End marker store followed by a spin in place
    task automatic finish_program();
        emit(encode_s(end_addr[11:0], 5'd0, 5'd0, 3'b010));
        emit(encode_j(21'd0, 5'd0));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reset, run and compare
    //////////////////////////////////////////////////////////////////////

    task automatic reset_dut();
        int i;
        @(posedge clk);
        #1 rst_n = 1'b0;
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            if (i == 3) begin
                rst_n = 1'b1;
            end
            @(negedge clk);
            checks++;
            assert (dmem_req.w_en === 1'b0 && dmem_req.r_en === 1'b0) else begin
                $display("ERR t=%0t: memory strobe active around reset", $time);
                errors++;
            end
        end
        // First fetch address after release
        checks++;
        assert (imem_addr === reset_vec) else begin
            $display("ERR t=%0t: imem_addr %08h after reset, expected %08h",
                     $time, imem_addr, reset_vec);
            errors++;
        end
    endtask

    task automatic check_ram(input string name);
        int i;
        for (i = 0; i < 64; i++) begin
            checks++;
            assert (ram[i] === exp_ram[i]) else begin
                $display("ERR t=%0t: %s word 0x%03h holds %08h, expected %08h",
                         $time, name, i * 4, ram[i], exp_ram[i]);
                errors++;
            end
        end
    endtask

    task automatic run_program(input string name);
        int  cycles;
        logic done;
        reset_dut();
        done   = 1'b0;
        cycles = 0;
        // Marker store is seen mid-cycle before its write edge
        while (!done && cycles < max_cycles) begin
            @(negedge clk);
            if (dmem_req.w_en === 1'b1 && dmem_req.addr === end_addr) begin
                done = 1'b1;
            end
            cycles++;
        end
        assert (done) else begin
            $display("%s: program never reached its end marker within %0d cycles",
                     name, max_cycles);
            errors++;
        end
        if (done) begin
            check_ram(name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    // x3 = x1 op x2
    task automatic reg_case(input logic [6:0] f7, input logic [2:0] f3, input word_t exp);
        emit(encode_r(f7, 5'd2, 5'd1, f3, 5'd3));
        save_reg(5'd3, exp);
    endtask

    // x3 = x1 op imm
    task automatic imm_case(input logic [11:0] imm, input logic [2:0] f3, input word_t exp);
        emit(encode_i(imm, 5'd1, f3, 5'd3, op_imm));
        save_reg(5'd3, exp);
    endtask

    task automatic alu_ops();
        word_t       a;
        word_t       b;
        word_t       r;
        word_t       imm_s;
        word_t       at;
        logic [11:0] imm;
        logic [4:0]  sh;
        int          round;
        start_program();
        for (round = 0; round < 2; round++) begin
            a     = next_random();
            b     = next_random();
            r     = next_random();
            imm   = r[11:0];
            imm_s = {{20{imm[11]}}, imm};
            sh    = b[4:0];
            load_imm(5'd1, a);
            load_imm(5'd2, b);
            // Register forms
            reg_case(7'h00, 3'd0, a + b);
            reg_case(7'h20, 3'd0, a - b);
            reg_case(7'h00, 3'd1, a << sh);
            reg_case(7'h00, 3'd2, {31'b0, $signed(a) < $signed(b)});
            reg_case(7'h00, 3'd3, {31'b0, a < b});
            reg_case(7'h00, 3'd4, a ^ b);
            reg_case(7'h00, 3'd5, a >> sh);
            reg_case(7'h20, 3'd5, $signed(a) >>> sh);
            reg_case(7'h00, 3'd6, a | b);
            reg_case(7'h00, 3'd7, a & b);
            // Immediate forms with sltiu against the extended immediate
            imm_case(imm, 3'd0, a + imm_s);
            imm_case(imm, 3'd2, {31'b0, $signed(a) < $signed(imm_s)});
            imm_case(imm, 3'd3, {31'b0, a < imm_s});
            imm_case(imm, 3'd4, a ^ imm_s);
            imm_case(imm, 3'd6, a | imm_s);
            imm_case(imm, 3'd7, a & imm_s);
            imm_case({7'h00, sh}, 3'd1, a << sh);
            imm_case({7'h00, sh}, 3'd5, a >> sh);
            imm_case({7'h20, sh}, 3'd5, $signed(a) >>> sh);
            // Upper immediates
            emit(encode_u(r[31:12], 5'd3, op_lui));
            save_reg(5'd3, {r[31:12], 12'b0});
            at = pc_emit * 4;
            emit(encode_u(r[31:12], 5'd3, op_auipc));
            save_reg(5'd3, at + {r[31:12], 12'b0});
        end
        // x0 stays zero after a write
        emit(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        save_reg(5'd0, 32'h0);
        finish_program();
        run_program("alu");
    endtask

    task automatic store_lanes();
        word_t p;
        word_t q;
        int    o;
        start_program();
        p = next_random();
        q = next_random();
        load_imm(5'd5, p);
        load_imm(5'd6, q);
        // sb at offset o into word o
        for (o = 0; o < 4; o++) begin
            emit(encode_s(12'(o * 5), 5'd5, 5'd0, 3'b000));
            exp_ram[o][o*8 +: 8] = p[7:0];
        end
        // sh at offsets 0 and 2
        emit(encode_s(12'd16, 5'd5, 5'd0, 3'b001));
        exp_ram[4][15:0] = p[15:0];
        emit(encode_s(12'd22, 5'd5, 5'd0, 3'b001));
        exp_ram[5][31:16] = p[15:0];
        // Full word and then one byte over its top lane
        emit(encode_s(12'd24, 5'd6, 5'd0, 3'b010));
        emit(encode_s(12'd27, 5'd5, 5'd0, 3'b000));
        exp_ram[6] = {p[7:0], q[23:0]};
        finish_program();
        run_program("stores");
    endtask

    task automatic load_case(input logic [2:0] f3, input logic [11:0] addr, input word_t exp);
        emit(encode_i(addr, 5'd0, f3, 5'd6, op_load));
        save_reg(5'd6, exp);
    endtask

    task automatic load_extension();
        word_t       w;
        logic [7:0]  b8;
        logic [15:0] h16;
        logic [11:0] base;
        int          k;
        int          o;
        start_program();
        // Mixed sign bits in every byte and half
        ram[128] = 32'h7f80_c17e;
        ram[129] = next_random();
        for (k = 0; k < 2; k++) begin
            w    = ram[128 + k];
            base = 12'h200 + 12'(k * 4);
            for (o = 0; o < 4; o++) begin
                b8 = w[o*8 +: 8];
                load_case(3'b000, base + 12'(o), {{24{b8[7]}}, b8});
                load_case(3'b100, base + 12'(o), {24'b0, b8});
            end
            for (o = 0; o < 4; o += 2) begin
                h16 = w[o*8 +: 16];
                load_case(3'b001, base + 12'(o), {{16{h16[15]}}, h16});
                load_case(3'b101, base + 12'(o), {16'b0, h16});
            end
            load_case(3'b010, base, w);
        end
        finish_program();
        run_program("loads");
    endtask

    // Branch over one marked store
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input word_t a, input word_t b);
        logic taken;
        case (f3)
            3'b000:  taken = a == b;
            3'b001:  taken = a != b;
            3'b100:  taken = $signed(a) < $signed(b);
            3'b101:  taken = $signed(a) >= $signed(b);
            3'b110:  taken = a < b;
            default: taken = a >= b;
        endcase
        emit(encode_b(13'd8, rs2, rs1, f3));
        save_reg(5'd7, taken ? fill_word(slot) : mark_value);
    endtask

    task automatic control_flow();
        word_t neg;
        word_t pos;
        word_t at;
        start_program();
        neg = 32'hffff_fffb;
        pos = 32'd3;
        load_imm(5'd1, neg);
        load_imm(5'd2, pos);
        load_imm(5'd3, pos);
        load_imm(5'd7, mark_value);
        // Each kind taken and not taken
        branch_case(3'b000, 5'd2, 5'd3, pos, pos);
        branch_case(3'b000, 5'd1, 5'd2, neg, pos);
        branch_case(3'b001, 5'd1, 5'd2, neg, pos);
        branch_case(3'b001, 5'd2, 5'd3, pos, pos);
        branch_case(3'b100, 5'd1, 5'd2, neg, pos);
        branch_case(3'b100, 5'd2, 5'd1, pos, neg);
        branch_case(3'b101, 5'd2, 5'd1, pos, neg);
        branch_case(3'b101, 5'd1, 5'd2, neg, pos);
        branch_case(3'b101, 5'd2, 5'd3, pos, pos);
        branch_case(3'b110, 5'd2, 5'd1, pos, neg);
        branch_case(3'b110, 5'd1, 5'd2, neg, pos);
        branch_case(3'b111, 5'd1, 5'd2, neg, pos);
        branch_case(3'b111, 5'd2, 5'd1, pos, neg);
        // JAL skips one store and links PC+4
        at = pc_emit * 4;
        emit(encode_j(21'd8, 5'd8));
        save_reg(5'd7, fill_word(slot));
        save_reg(5'd8, at + 4);
        // JALR lands on an odd sum with bit 0 dropped
        at = pc_emit * 4;
        load_imm(5'd9, at + 16 - 2);
        emit(encode_i(12'd3, 5'd9, 3'b000, 5'd10, op_jalr));
        save_reg(5'd7, fill_word(slot));
        // Landing PC read back through AUIPC
        emit(encode_u(20'd0, 5'd11, op_auipc));
        save_reg(5'd11, at + 16);
        save_reg(5'd10, at + 12);
        finish_program();
        run_program("control");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        imem_r_data = '0;
        dmem_r_data = '0;
        errors      = 0;
        checks      = 0;
        rng_state   = 32'd7;
        alu_ops();
        store_lanes();
        load_extension();
        control_flow();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/otter_pkg.sv
rtl/otter_regfile.sv
rtl/otter_alu.sv
rtl/otter_pc_unit.sv
rtl/otter_mem_align.sv
rtl/otter_control.sv
rtl/otter_mcu.sv
bench/otter_tb.sv
